// File: src.f
src/ncpu32k_pkg.sv
src/ncpu32k_cell_pipebuf.sv
src/ncpu32k_issue.sv
src/ncpu32k_alu.sv
src/ncpu32k_mul.sv
src/ncpu32k_commit.sv
src/ncpu32k_exec_top.sv
verification/tb_exec_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execution back end testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exec_top -f src.f -o sim_exec_top

./obj_dir/sim_exec_top | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

// File: verification/tb_exec_top.sv
/*
 * Directed testbench for the dual-lane execution back end.
 * Each test task drives micro-ops into the DUT, a reference model
 * predicts every result and a monitor checks results in issue order.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_top;

   localparam int max_cycles = 2000;   // Covers about 460 ops with margin
   localparam logic [31:0] corner [6] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                                          32'h7fff_ffff, 32'h0000_0001, 32'h0000_ffff};

   logic                 clk;
   logic                 reset;
   ncpu32k_pkg::uop_t    uop;
   logic                 uop_valid;
   logic                 uop_ready;
   ncpu32k_pkg::result_t res;
   logic                 res_valid;
   logic                 res_ready;

   ncpu32k_pkg::result_t exp_q [$];          // Expected results, oldest first
   integer               seed = 69;
   int                   ready_mode = 0;     // 0 high, 1 random, 2 low
   int                   err_count = 0;
   int                   tests_passed = 0;
   int                   tests_failed = 0;
   int                   cycle_count = 0;
   logic [4:0]           next_tag = 5'd0;
   logic [31:0]          coin;
   logic                 next_ready;

   ncpu32k_exec_top u_ncpu32k_exec_top (
      .clk (clk), .reset (reset),
      .uop (uop), .uop_valid (uop_valid), .uop_ready (uop_ready),
      .res (res), .res_valid (res_valid), .res_ready (res_ready)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model and result checking
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic ncpu32k_pkg::result_t compute_expected(input ncpu32k_pkg::uop_t u);
      ncpu32k_pkg::result_t r;
      logic signed [63:0]   prod;
      prod  = $signed({{32{u.a[31]}}, u.a}) * $signed({{32{u.b[31]}}, u.b});   // Signed 64-bit
      r.tag = u.tag;
      case (u.op)
         ncpu32k_pkg::op_add:  r.data = u.a + u.b;
         ncpu32k_pkg::op_sub:  r.data = u.a - u.b;
         ncpu32k_pkg::op_and:  r.data = u.a & u.b;
         ncpu32k_pkg::op_or:   r.data = u.a | u.b;
         ncpu32k_pkg::op_xor:  r.data = u.a ^ u.b;
         ncpu32k_pkg::op_slt:  r.data = ($signed(u.a) < $signed(u.b)) ? 32'd1 : 32'd0;
         ncpu32k_pkg::op_mul:  r.data = prod[31:0];    // Low word
         default:              r.data = prod[63:32];   // High word
      endcase
      return r;
   endfunction

   task automatic check_result(input ncpu32k_pkg::result_t got);
      ncpu32k_pkg::result_t want;
      assert (exp_q.size() != 0) else begin
         $display("Result with tag %h arrived while no op was outstanding", got.tag);
         err_count++;
      end
      if (exp_q.size() != 0) begin
         want = exp_q.pop_front();
         assert (got.tag == want.tag) else begin
            $display("Error: res.tag expected %h got %h", want.tag, got.tag);
            err_count++;
         end
         assert (got.data == want.data) else begin
            $display("Error: res.data expected %h got %h (tag %h)", want.data, got.data, want.tag);
            err_count++;
         end
      end
   endtask

   always @(negedge clk) begin
      if (!reset && res_valid && res_ready) check_result(res);   // Transfers on next edge
   end

   initial begin
      res_ready = 1'b1;
      forever begin
         @(negedge clk);
         coin = $random(seed);   // Next cycle's ready chosen mid-cycle
         case (ready_mode)
            1:       next_ready = coin[0];   // Random back-pressure
            2:       next_ready = 1'b0;
            default: next_ready = 1'b1;
         endcase
         @(posedge clk);
         res_ready <= next_ready;
      end
   end

   initial begin
      while (cycle_count < max_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout, the run hung with %0d results still outstanding", exp_q.size());
      $display("*** FAILED ***");
      $finish;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus helpers called right after a rising edge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic send_op(input ncpu32k_pkg::opcode_t op, input logic [31:0] a,
                          input logic [31:0] b);
      ncpu32k_pkg::uop_t u;
      logic              accepted;
      u.op      = op;
      u.a       = a;
      u.b       = b;
      u.tag     = next_tag;
      uop       <= u;
      uop_valid <= 1'b1;
      accepted  = 1'b0;
      while (!accepted) begin
         @(negedge clk);
         accepted = uop_ready;   // Stable mid-cycle
         @(posedge clk);
      end
      exp_q.push_back(compute_expected(u));
      next_tag = next_tag + 5'd1;
   endtask

   task automatic wait_drain;
      uop_valid <= 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      @(posedge clk);
   endtask

   task automatic finish_test(input string name, input int errs_at_start);
      int errs;
      errs = err_count - errs_at_start;
      if (errs == 0) begin
         tests_passed++;
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, errs);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic check_reset_state;
      int errs;
      errs = err_count;
      @(negedge clk);
      assert (res_valid == 1'b0) else begin
         $display("Error: res_valid expected %h got %h", 1'b0, res_valid);
         err_count++;
      end
      assert (uop_ready == 1'b1) else begin
         $display("Error: uop_ready expected %h got %h", 1'b1, uop_ready);
         err_count++;
      end
      @(posedge clk);
      finish_test("check_reset_state", errs);
   endtask

   task automatic alu_function_sweep;
      int                   errs;
      logic [31:0]          ra;
      logic [31:0]          rb;
      ncpu32k_pkg::opcode_t op;
      errs = err_count;
      for (int k = 0; k < 6; k++) begin
         op = ncpu32k_pkg::opcode_t'(k[2:0]);   // add through slt
         for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) send_op(op, corner[i], corner[j]);
         end
         repeat (6) begin
            ra = $random(seed);
            rb = $random(seed);
            send_op(op, ra, rb);
         end
      end
      wait_drain();
      finish_test("alu_function_sweep", errs);
   endtask

   task automatic mul_corner_sweep;
      int                   errs;
      logic [31:0]          ra;
      logic [31:0]          rb;
      ncpu32k_pkg::opcode_t op;
      errs = err_count;
      for (int k = 0; k < 2; k++) begin
         op = (k == 0) ? ncpu32k_pkg::op_mul : ncpu32k_pkg::op_mulh;
         for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) send_op(op, corner[i], corner[j]);
         end
         repeat (6) begin
            ra = $random(seed);
            rb = $random(seed);
            send_op(op, ra, rb);
         end
      end
      wait_drain();
      finish_test("mul_corner_sweep", errs);
   endtask

   task automatic mixed_lane_order;
      int          errs;
      logic [31:0] ra;
      logic [31:0] rb;
      errs = err_count;
      repeat (20) begin
         ra = $random(seed);
         rb = $random(seed);
         send_op(ra[0] ? ncpu32k_pkg::op_mulh : ncpu32k_pkg::op_mul, ra, rb);
         send_op(ncpu32k_pkg::opcode_t'(rb[2:0] % 3'd6), rb, ra);   // ALU op overtakes inside
      end
      wait_drain();
      finish_test("mixed_lane_order", errs);
   endtask

   task automatic random_backpressure;
      int          errs;
      logic [31:0] ra;
      logic [31:0] rb;
      errs = err_count;
      ready_mode = 1;
      repeat (80) begin
         ra = $random(seed);
         rb = $random(seed);
         send_op(ncpu32k_pkg::opcode_t'(ra[2:0]), ra, rb);
      end
      wait_drain();
      ready_mode = 0;
      finish_test("random_backpressure", errs);
   endtask

   task automatic stall_and_drain;
      int          errs;
      int          accepted;
      logic [31:0] ra;
      errs       = err_count;
      accepted   = 0;
      ready_mode = 2;
      @(posedge clk);
      for (int i = 0; i < 16; i++) begin
         @(negedge clk);
         if (!uop_ready) break;   // Queue and buffers are full
         @(posedge clk);
         ra = $random(seed);
         send_op(i[0] ? ncpu32k_pkg::op_mul : ncpu32k_pkg::op_add, ra, 32'(i));
         uop_valid <= 1'b0;
         accepted++;
      end
      repeat (4) @(posedge clk);
      // Queue entries plus the issue register and output buffer
      assert (accepted <= ncpu32k_pkg::order_depth + 2 && accepted >= ncpu32k_pkg::order_depth)
      else begin
         $display("Error: accepted ops expected %h to %h got %h", ncpu32k_pkg::order_depth,
                  ncpu32k_pkg::order_depth + 2, accepted);
         err_count++;
      end
      assert (exp_q.size() == accepted) else begin
         $display("A result left the DUT while res_ready was held low");
         err_count++;
      end
      ready_mode = 0;
      wait_drain();
      finish_test("stall_and_drain", errs);
   endtask

   initial begin
      uop       = '0;
      uop_valid = 1'b0;
      reset     = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      check_reset_state();
      alu_function_sweep();
      mul_corner_sweep();
      mixed_lane_order();
      random_backpressure();
      stall_and_drain();
      $display("Tests passed %0d, failed %0d, check errors %0d",
               tests_passed, tests_failed, err_count);
      if (tests_failed == 0 && err_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src/ncpu32k_exec_top.sv
/*
 * Execution back end top level. Connects issue, the ALU and
 * multiplier lanes and commit; one micro-op port in, one result out.
 */
`timescale 1ns/1ns
`default_nettype none

module ncpu32k_exec_top (
   input  logic                   clk,
   input  logic                   reset,
   input  ncpu32k_pkg::uop_t      uop,
   input  logic                   uop_valid,
   output logic                   uop_ready,
   output ncpu32k_pkg::result_t   res,
   output logic                   res_valid,
   input  logic                   res_ready
);

   ncpu32k_pkg::uop_t    alu_uop;       // Issue to ALU
   logic                 alu_valid;
   logic                 alu_ready;
   ncpu32k_pkg::uop_t    mul_uop;       // Issue to multiplier
   logic                 mul_valid;
   logic                 mul_ready;
   logic                 order_push;    // Issue to commit
   ncpu32k_pkg::lane_t   order_lane;
   logic                 order_ready;
   ncpu32k_pkg::result_t alu_res;       // Lanes to commit
   logic                 alu_res_valid;
   logic                 alu_res_ready;
   ncpu32k_pkg::result_t mul_res;
   logic                 mul_res_valid;
   logic                 mul_res_ready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Units
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   ncpu32k_issue u_issue (
      .clk (clk), .reset (reset),
      .uop (uop), .uop_valid (uop_valid), .uop_ready (uop_ready),
      .alu_uop (alu_uop), .alu_valid (alu_valid), .alu_ready (alu_ready),
      .mul_uop (mul_uop), .mul_valid (mul_valid), .mul_ready (mul_ready),
      .order_push (order_push), .order_lane (order_lane), .order_ready (order_ready)
   );

   ncpu32k_alu u_alu (
      .clk (clk), .reset (reset),
      .uop (alu_uop), .in_valid (alu_valid), .in_ready (alu_ready),
      .res (alu_res), .res_valid (alu_res_valid), .res_ready (alu_res_ready)
   );

   ncpu32k_mul u_mul (
      .clk (clk), .reset (reset),
      .uop (mul_uop), .in_valid (mul_valid), .in_ready (mul_ready),
      .res (mul_res), .res_valid (mul_res_valid), .res_ready (mul_res_ready)
   );

   ncpu32k_commit u_commit (
      .clk (clk), .reset (reset),
      .order_push (order_push), .order_lane (order_lane), .order_ready (order_ready),
      .alu_res (alu_res), .alu_valid (alu_res_valid), .alu_ready (alu_res_ready),
      .mul_res (mul_res), .mul_valid (mul_res_valid), .mul_ready (mul_res_ready),
      .res (res), .res_valid (res_valid), .res_ready (res_ready)
   );

endmodule

`default_nettype wire

// File: src/ncpu32k_commit.sv
/*
 * Commit unit. A small lane queue records the lane of every issued op
 * in order; only the head lane's result is accepted and forwarded to
 * the output buffer, so results leave strictly in issue order.
 */
`timescale 1ns/1ns
`default_nettype none

module ncpu32k_commit (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   order_push,
   input  ncpu32k_pkg::lane_t     order_lane,
   output logic                   order_ready,
   input  ncpu32k_pkg::result_t   alu_res,
   input  logic                   alu_valid,
   output logic                   alu_ready,
   input  ncpu32k_pkg::result_t   mul_res,
   input  logic                   mul_valid,
   output logic                   mul_ready,
   output ncpu32k_pkg::result_t   res,
   output logic                   res_valid,
   input  logic                   res_ready
);

   ncpu32k_pkg::lane_t     lane_q [ncpu32k_pkg::order_depth];   // Lane per op with oldest at rd_ptr
   ncpu32k_pkg::order_ptr_t wr_ptr;
   ncpu32k_pkg::order_ptr_t rd_ptr;
   ncpu32k_pkg::order_cnt_t count;

   ncpu32k_pkg::lane_t     head;
   logic                   not_empty;
   logic                   head_mul;
   ncpu32k_pkg::result_t   sel_res;
   logic                   sel_valid;
   logic                   buf_ready;   // Output buffer room
   logic                   pop;

   assign order_ready = (count != ncpu32k_pkg::order_full);
   assign not_empty   = (count != '0);
   assign head        = lane_q[rd_ptr];
   assign head_mul    = (head == ncpu32k_pkg::lane_mul);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Head lane select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign sel_res   = head_mul ? mul_res : alu_res;
   assign sel_valid = not_empty & (head_mul ? mul_valid : alu_valid);
   assign alu_ready = not_empty & ~head_mul & buf_ready;   // Other lane waits
   assign mul_ready = not_empty &  head_mul & buf_ready;
   assign pop       = sel_valid & buf_ready;

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (order_push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)        rd_ptr <= rd_ptr + 1'b1;
         case ({order_push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (order_push) lane_q[wr_ptr] <= order_lane;   // Queue storage
   end

   ncpu32k_cell_pipebuf #(
      .payload_t     (ncpu32k_pkg::result_t),
      .enable_bypass (1'b1)
   ) u_out_buf (
      .clk       (clk),
      .reset     (reset),
      .din       (sel_res),
      .in_valid  (sel_valid),
      .in_ready  (buf_ready),
      .dout      (res),
      .out_valid (res_valid),
      .out_ready (res_ready)
   );

endmodule

`default_nettype wire

// File: src/ncpu32k_mul.sv
/*
 * Two-stage signed 32-bit multiplier lane. Stage one forms four
 * 16x16 partial products, stage two sums them to the 64-bit product
 * and returns the low word (op_mul) or high word (op_mulh).
 */
`timescale 1ns/1ns
`default_nettype none

module ncpu32k_mul (
   input  logic                   clk,
   input  logic                   reset,
   input  ncpu32k_pkg::uop_t      uop,
   input  logic                   in_valid,
   output logic                   in_ready,
   output ncpu32k_pkg::result_t   res,
   output logic                   res_valid,
   input  logic                   res_ready
);

   typedef struct packed {
      logic        [31:0]                   pp_ll;   // Unsigned al * bl
      logic signed [31:0]                   pp_lh;   // al * bh
      logic signed [31:0]                   pp_hl;   // ah * bl
      logic signed [31:0]                   pp_hh;   // ah * bh
      logic                                 hi;      // High word wanted
      logic        [ncpu32k_pkg::tag_width-1:0] tag;
   } stage_t;

   stage_t               s0;          // Stage one input
   stage_t               s1;          // Stage one register
   logic                 s1_valid;
   logic                 s1_ready;
   logic [63:0]          prod;        // Full product
   ncpu32k_pkg::result_t s2;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stage one partial products
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      s0.pp_ll = {16'd0, uop.a[15:0]} * {16'd0, uop.b[15:0]};
      s0.pp_lh = $signed({16'd0, uop.a[15:0]}) * $signed({{16{uop.b[31]}}, uop.b[31:16]});
      s0.pp_hl = $signed({{16{uop.a[31]}}, uop.a[31:16]}) * $signed({16'd0, uop.b[15:0]});
      s0.pp_hh = $signed({{16{uop.a[31]}}, uop.a[31:16]}) *
                 $signed({{16{uop.b[31]}}, uop.b[31:16]});
      s0.hi    = (uop.op == ncpu32k_pkg::op_mulh);
      s0.tag   = uop.tag;
   end

   ncpu32k_cell_pipebuf #(
      .payload_t     (stage_t),
      .enable_bypass (1'b0)
   ) u_pp_buf (
      .clk       (clk),
      .reset     (reset),
      .din       (s0),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .dout      (s1),
      .out_valid (s1_valid),
      .out_ready (s1_ready)
   );

   // Stage two sums the shifted partial products
   assign prod = {32'd0, s1.pp_ll}
               + {{16{s1.pp_lh[31]}}, s1.pp_lh, 16'd0}
               + {{16{s1.pp_hl[31]}}, s1.pp_hl, 16'd0}
               + {s1.pp_hh, 32'd0};

   assign s2.data = s1.hi ? prod[63:32] : prod[31:0];   // Word select
   assign s2.tag  = s1.tag;

   ncpu32k_cell_pipebuf #(
      .payload_t     (ncpu32k_pkg::result_t),
      .enable_bypass (1'b1)
   ) u_res_buf (
      .clk       (clk),
      .reset     (reset),
      .din       (s2),
      .in_valid  (s1_valid),
      .in_ready  (s1_ready),
      .dout      (res),
      .out_valid (res_valid),
      .out_ready (res_ready)
   );

endmodule

`default_nettype wire

// File: src/ncpu32k_alu.sv
/*
 * Integer ALU lane. Computes add, sub, and, or, xor and signed
 * set-less-than in one cycle and registers the result with its tag.
 */
`timescale 1ns/1ns
`default_nettype none

module ncpu32k_alu (
   input  logic                   clk,
   input  logic                   reset,
   input  ncpu32k_pkg::uop_t      uop,
   input  logic                   in_valid,
   output logic                   in_ready,
   output ncpu32k_pkg::result_t   res,
   output logic                   res_valid,
   input  logic                   res_ready
);

   ncpu32k_pkg::result_t alu_out;   // Combinational result
   logic                 lt;

   assign lt = $signed(uop.a) < $signed(uop.b);   // Signed compare

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Function select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      alu_out     = '0;
      alu_out.tag = uop.tag;   // Tag rides through
      case (uop.op)
         ncpu32k_pkg::op_add: alu_out.data = uop.a + uop.b;
         ncpu32k_pkg::op_sub: alu_out.data = uop.a - uop.b;
         ncpu32k_pkg::op_and: alu_out.data = uop.a & uop.b;
         ncpu32k_pkg::op_or:  alu_out.data = uop.a | uop.b;
         ncpu32k_pkg::op_xor: alu_out.data = uop.a ^ uop.b;
         ncpu32k_pkg::op_slt: begin
            alu_out.data = {{(ncpu32k_pkg::data_width-1){1'b0}}, lt};   // 1 or 0
         end
         default: alu_out.data = '0;   // Multiply ops never routed here
      endcase
   end

   // Result register
   ncpu32k_cell_pipebuf #(
      .payload_t     (ncpu32k_pkg::result_t),
      .enable_bypass (1'b1)
   ) u_res_buf (
      .clk       (clk),
      .reset     (reset),
      .din       (alu_out),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .dout      (res),
      .out_valid (res_valid),
      .out_ready (res_ready)
   );

endmodule

`default_nettype wire

// File: src/ncpu32k_issue.sv
/*
 * Issue unit. Registers incoming micro-ops, routes each one to the ALU
 * or multiplier lane and records the lane in the commit queue.
 * An op leaves only when its lane and the lane queue both have room.
 */
`timescale 1ns/1ns
`default_nettype none

module ncpu32k_issue (
   input  logic                 clk,
   input  logic                 reset,
   input  ncpu32k_pkg::uop_t    uop,
   input  logic                 uop_valid,
   output logic                 uop_ready,
   output ncpu32k_pkg::uop_t    alu_uop,
   output logic                 alu_valid,
   input  logic                 alu_ready,
   output ncpu32k_pkg::uop_t    mul_uop,
   output logic                 mul_valid,
   input  logic                 mul_ready,
   output logic                 order_push,
   output ncpu32k_pkg::lane_t   order_lane,
   input  logic                 order_ready
);

   ncpu32k_pkg::uop_t q_uop;   // Held op
   logic              q_valid;
   logic              q_ready;
   logic              is_mul;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Issue register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   ncpu32k_cell_pipebuf #(
      .payload_t     (ncpu32k_pkg::uop_t),
      .enable_bypass (1'b1)
   ) u_issue_buf (
      .clk       (clk),
      .reset     (reset),
      .din       (uop),
      .in_valid  (uop_valid),
      .in_ready  (uop_ready),
      .dout      (q_uop),
      .out_valid (q_valid),
      .out_ready (q_ready)
   );

   assign is_mul = (q_uop.op == ncpu32k_pkg::op_mul) |
                   (q_uop.op == ncpu32k_pkg::op_mulh);   // Lane select

   // Target lane only, and only while the queue has a free entry
   assign alu_uop   = q_uop;
   assign mul_uop   = q_uop;
   assign alu_valid = q_valid & ~is_mul & order_ready;
   assign mul_valid = q_valid &  is_mul & order_ready;

   assign q_ready = order_ready & (is_mul ? mul_ready : alu_ready);   // Pops on lane handshake

   assign order_push = q_valid & q_ready;   // Same edge as lane transfer
   assign order_lane = is_mul ? ncpu32k_pkg::lane_mul : ncpu32k_pkg::lane_alu;

endmodule

`default_nettype wire

// File: src/ncpu32k_cell_pipebuf.sv
/*
 * One-slot valid/ready pipe buffer with a type-parameter payload.
 * Bypass on lets a new item in during the pop cycle for full rate;
 * bypass off makes in_ready depend on local state only.
 */
`timescale 1ns/1ns
`default_nettype none

module ncpu32k_cell_pipebuf #(
   parameter type payload_t     = logic,
   parameter bit  enable_bypass = 1'b1
) (
   input  logic     clk,
   input  logic     reset,
   input  payload_t din,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t dout,
   output logic     out_valid,
   input  logic     out_ready
);

   logic push;
   logic pop;

   assign push = in_valid & in_ready;   // Slot loads
   assign pop  = out_valid & out_ready; // Slot drains

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (push) begin
         out_valid <= 1'b1;              // Push wins over pop
      end else if (pop) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         dout <= din;                    // Payload register
      end
   end

   generate
      if (enable_bypass) begin : g_bypass
         assign in_ready = ~out_valid | pop;   // Refill while draining
      end else begin : g_no_bypass
         assign in_ready = ~out_valid;         // Empty only
      end
   endgenerate

endmodule

`default_nettype wire

// File: src/ncpu32k_pkg.sv
/*
 * Shared definitions for the dual-lane execution back end:
 * widths, opcodes, micro-op and result payloads and lane-queue sizing.
 * Every RTL file refers to these by scoped name.
 */
`default_nettype none

package ncpu32k_pkg;

   localparam int data_width  = 32;   // Operand and result width
   localparam int tag_width   = 5;    // Destination register tag
   localparam int order_depth = 4;    // Lane queue entries as a power of two

   localparam int order_ptr_width = $clog2(order_depth);
   localparam int order_cnt_width = $clog2(order_depth + 1);

   typedef logic [order_ptr_width-1:0] order_ptr_t;   // Lane queue index
   typedef logic [order_cnt_width-1:0] order_cnt_t;   // Lane queue fill level

   localparam order_cnt_t order_full = order_cnt_t'(order_depth);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Micro-op encoding
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [2:0] {
      op_add  = 3'd0,
      op_sub  = 3'd1,
      op_and  = 3'd2,
      op_or   = 3'd3,
      op_xor  = 3'd4,
      op_slt  = 3'd5,   // Signed compare
      op_mul  = 3'd6,   // Low product word
      op_mulh = 3'd7    // Signed high product word
   } opcode_t;

   typedef struct packed {
      opcode_t               op;
      logic [data_width-1:0] a;     // Operand a
      logic [data_width-1:0] b;     // Operand b
      logic [tag_width-1:0]  tag;   // Destination tag
   } uop_t;

   typedef struct packed {
      logic [data_width-1:0] data;
      logic [tag_width-1:0]  tag;
   } result_t;

   // Which lane an issued op went to
   typedef enum logic {
      lane_alu = 1'b0,
      lane_mul = 1'b1
   } lane_t;

endpackage

`default_nettype wire
